/* Makefile */
VERILATOR   ?= verilator
TOP         ?= flow_sched_tb
FILELIST    ?= flow_sched.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS  ?= --lint-only --timing -Wall
PASS_TEXT   ?= RESULT: PASS

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* flow_sched.f */
source/sched_pkg.sv
source/slot_keeper.sv
source/slot_pool.sv
source/rr_arbiter.sv
source/desc_allocator.sv
source/host_cmd_regs.sv
source/flow_sched_top.sv
tb/tb_clock_gen.sv
tb/flow_sched_tb.sv

/* source/desc_allocator.sv */
// Interface selection and descriptor allocation
`default_nettype none

module desc_allocator (
  input  logic                                                       clk,
  input  logic                                                       rst_r,
  input  logic [sched_pkg::if_count-1:0]                             hash_valid,
  input  logic [sched_pkg::if_count-1:0][sched_pkg::hash_width-1:0]  hash_value,
  input  logic [sched_pkg::core_count-1:0][sched_pkg::slot_width-1:0] slot_head,
  input  logic [sched_pkg::core_count-1:0]                           slot_head_valid,
  input  logic [sched_pkg::core_count-1:0]                           income_cores,
  input  logic [sched_pkg::if_count-1:0]                             almost_full,
  output logic [sched_pkg::if_count-1:0]                             hash_pop,
  output logic [sched_pkg::if_count-1:0]                             alloc_valid,
  output logic [sched_pkg::if_count-1:0]                             alloc_drop,
  output logic [sched_pkg::if_count-1:0][sched_pkg::dest_width-1:0]  alloc_dest,
  output logic [sched_pkg::core_count-1:0]                           slot_pop,
  output logic [sched_pkg::if_count-1:0][31:0]                       drop_count
);
  import sched_pkg::*;

  logic [if_count-1:0]      request;
  logic [if_count-1:0]      grant;
  logic                     grant_valid;
  logic [if_id_width-1:0]   grant_enc;
  logic [if_count-1:0]      grant_r;
  logic                     grant_v_r;
  logic [if_id_width-1:0]   grant_enc_r;
  logic [core_id_width-1:0] dest_core_r;
  logic                     avail;
  logic                     do_alloc;
  logic                     do_drop;
  logic [dest_width-1:0]    dest;

  // The slot check takes a cycle, so last cycle's grant sits out
  assign request = hash_valid & ~grant_r;

  rr_arbiter #(.ports(if_count)) u_arb (
    .clk        (clk),
    .rst_r      (rst_r),
    .request    (request),
    .grant      (grant),
    .grant_valid(grant_valid),
    .grant_enc  (grant_enc)
  );

  always_ff @(posedge clk) begin
    if (rst_r) begin
      grant_r     <= '0;
      grant_v_r   <= 1'b0;
      grant_enc_r <= '0;
      dest_core_r <= '0;
    end else begin
      grant_r     <= grant;
      grant_v_r   <= grant_valid;
      grant_enc_r <= grant_enc;
      dest_core_r <= hash_value[grant_enc][hash_sel_offset +: core_id_width];
    end
  end

  assign avail    = slot_head_valid[dest_core_r] && income_cores[dest_core_r];
  assign do_alloc = grant_v_r && avail;
  assign do_drop  = grant_v_r && !avail && almost_full[grant_enc_r];
  assign dest     = {dest_core_r, tag_width'(slot_head[dest_core_r])};

  assign hash_pop    = (do_alloc || do_drop) ? grant_r : '0;
  assign alloc_valid = hash_pop;
  assign alloc_drop  = do_drop ? grant_r : '0;
  assign alloc_dest  = {if_count{dest}};
  assign slot_pop    = do_alloc ? (core_count'(1) << dest_core_r) : '0;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      drop_count <= '0;
    end else if (do_drop) begin
      drop_count[grant_enc_r] <= drop_count[grant_enc_r] + 32'd1;
    end
  end

  // Producers hold the hash until it is popped
  pop_only_valid: assert property (@(posedge clk) disable iff (rst_r)
    (hash_pop & ~hash_valid) == '0);

endmodule

`default_nettype wire

/* source/flow_sched_top.sv */
// Flow scheduler top level
`default_nettype none

module flow_sched_top (
  input  logic                                                      clk,
  input  logic                                                      rst_r,
  input  logic                                                      ctrl_valid,
  input  logic [sched_pkg::msg_type_width-1:0]                      ctrl_type,
  input  logic [sched_pkg::core_id_width-1:0]                       ctrl_core,
  input  logic [sched_pkg::slot_width-1:0]                          ctrl_slot,
  input  logic [sched_pkg::if_count-1:0]                            hash_valid,
  input  logic [sched_pkg::if_count-1:0][sched_pkg::hash_width-1:0] hash_value,
  input  logic [sched_pkg::if_count-1:0][sched_pkg::lines_width-1:0] line_count,
  input  logic [31:0]                                               host_cmd,
  input  logic [31:0]                                               host_wr_data,
  input  logic                                                      host_cmd_valid,
  output logic [sched_pkg::if_count-1:0]                            hash_pop,
  output logic [sched_pkg::if_count-1:0]                            alloc_valid,
  output logic [sched_pkg::if_count-1:0]                            alloc_drop,
  output logic [sched_pkg::if_count-1:0][sched_pkg::dest_width-1:0] alloc_dest,
  output logic [31:0]                                               host_rd_data,
  output logic                                                      slot_err
);
  import sched_pkg::*;

  logic [core_count-1:0]                 income_cores;
  logic [core_count-1:0]                 slots_flush;
  logic [if_count-1:0]                   almost_full;
  logic [core_count-1:0][slot_width-1:0] slot_head;
  logic [core_count-1:0]                 slot_head_valid;
  logic [core_count-1:0][slot_width-1:0] slot_count;
  logic [core_count-1:0]                 slot_pop;
  logic [if_count-1:0][31:0]             drop_count;

  slot_pool u_pool (
    .clk(clk), .rst_r(rst_r),
    .ctrl_valid(ctrl_valid), .ctrl_type(ctrl_type),
    .ctrl_core(ctrl_core), .ctrl_slot(ctrl_slot),
    .slots_flush(slots_flush), .slot_pop(slot_pop),
    .slot_head(slot_head), .slot_head_valid(slot_head_valid),
    .slot_count(slot_count), .slot_err(slot_err)
  );

  desc_allocator u_alloc (
    .clk(clk), .rst_r(rst_r),
    .hash_valid(hash_valid), .hash_value(hash_value),
    .slot_head(slot_head), .slot_head_valid(slot_head_valid),
    .income_cores(income_cores), .almost_full(almost_full),
    .hash_pop(hash_pop), .alloc_valid(alloc_valid),
    .alloc_drop(alloc_drop), .alloc_dest(alloc_dest),
    .slot_pop(slot_pop), .drop_count(drop_count)
  );

  // The enabled mask is only used inside the host block
  host_cmd_regs u_host (
    .clk(clk), .rst_r(rst_r),
    .host_cmd(host_cmd), .host_wr_data(host_wr_data),
    .host_cmd_valid(host_cmd_valid), .line_count(line_count),
    .slot_count(slot_count), .drop_count(drop_count),
    .enabled_cores(), .income_cores(income_cores),
    .slots_flush(slots_flush), .almost_full(almost_full),
    .host_rd_data(host_rd_data)
  );

endmodule

`default_nettype wire

/* source/host_cmd_regs.sv */
// Host command registers
`default_nettype none

module host_cmd_regs (
  input  logic                                                      clk,
  input  logic                                                      rst_r,
  input  logic [31:0]                                               host_cmd,
  input  logic [31:0]                                               host_wr_data,
  input  logic                                                      host_cmd_valid,
  input  logic [sched_pkg::if_count-1:0][sched_pkg::lines_width-1:0] line_count,
  input  logic [sched_pkg::core_count-1:0][sched_pkg::slot_width-1:0] slot_count,
  input  logic [sched_pkg::if_count-1:0][31:0]                      drop_count,
  output logic [sched_pkg::core_count-1:0]                          enabled_cores,
  output logic [sched_pkg::core_count-1:0]                          income_cores,
  output logic [sched_pkg::core_count-1:0]                          slots_flush,
  output logic [sched_pkg::if_count-1:0]                            almost_full,
  output logic [31:0]                                               host_rd_data
);
  import sched_pkg::*;

  logic                     wr_r;
  logic                     to_if_r;
  logic [cmd_reg_width-1:0] reg_r;
  logic [core_id_width-1:0] core_idx_r;
  logic [if_id_width-1:0]   if_idx_r;
  logic [31:0]              wr_data_r;
  logic [31:0]              rd_next;
  logic [lines_width-1:0]   drop_limit;

  always_ff @(posedge clk) begin
    to_if_r    <= host_cmd[cmd_if_bit];
    reg_r      <= host_cmd[cmd_reg_width-1:0];
    core_idx_r <= host_cmd[cmd_idx_lsb +: core_id_width];
    if_idx_r   <= host_cmd[cmd_idx_lsb +: if_id_width];
    wr_data_r  <= host_wr_data;
  end

  // Writes need both the write and the scheduler bit
  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_r          <= 1'b0;
      enabled_cores <= '0;
      income_cores  <= '0;
      slots_flush   <= '0;
      drop_limit    <= drop_limit_reset;
    end else begin
      wr_r        <= host_cmd_valid && host_cmd[cmd_wr_bit] && host_cmd[cmd_sched_bit];
      slots_flush <= '0;
      if (wr_r && !to_if_r && reg_r == reg_enabled) begin
        // A core taken out of service stops receiving too
        enabled_cores <= wr_data_r[core_count-1:0];
        income_cores  <= income_cores & wr_data_r[core_count-1:0];
      end
      if (wr_r && !to_if_r && reg_r == reg_income) begin
        income_cores <= wr_data_r[core_count-1:0] & enabled_cores;
      end
      if (wr_r && !to_if_r && reg_r == reg_flush) begin
        slots_flush <= wr_data_r[core_count-1:0];
      end
      if (wr_r && to_if_r && reg_r == reg_drop_limit) begin
        drop_limit <= wr_data_r[lines_width-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      almost_full <= '0;
    end else begin
      for (int i = 0; i < if_count; i++) begin
        almost_full[i] <= (line_count[i] >= drop_limit);
      end
    end
  end

  // Two-stage readback
  always_ff @(posedge clk) begin
    if (!to_if_r && reg_r == reg_enabled) begin
      rd_next <= 32'(enabled_cores);
    end else if (!to_if_r && reg_r == reg_income) begin
      rd_next <= 32'(income_cores);
    end else if (!to_if_r && reg_r == reg_slot_count) begin
      rd_next <= 32'(slot_count[core_idx_r]);
    end else if (to_if_r && reg_r == reg_drop_count) begin
      rd_next <= drop_count[if_idx_r];
    end else begin
      rd_next <= rd_default;
    end
    host_rd_data <= rd_next;
  end

endmodule

`default_nettype wire

/* source/rr_arbiter.sv */
// Round-robin arbiter
`default_nettype none

module rr_arbiter #(
  parameter int ports = sched_pkg::if_count
) (
  input  logic                       clk,
  input  logic                       rst_r,
  input  logic [ports-1:0]           request,
  output logic [ports-1:0]           grant,
  output logic                       grant_valid,
  output logic [$clog2(ports)-1:0]   grant_enc
);

  logic [$clog2(ports)-1:0] last_enc;

  // Search starts just after the port granted last
  always_comb begin
    int idx;
    grant       = '0;
    grant_valid = 1'b0;
    grant_enc   = '0;
    for (int k = 1; k <= ports; k++) begin
      idx = (int'(last_enc) + k) % ports;
      if (!grant_valid && request[idx]) begin
        grant[idx]  = 1'b1;
        grant_valid = 1'b1;
        grant_enc   = idx[$clog2(ports)-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      last_enc <= '1;
    end else if (grant_valid) begin
      last_enc <= grant_enc;
    end
  end

  grant_onehot: assert property (@(posedge clk) disable iff (rst_r) $onehot0(grant));

endmodule

`default_nettype wire

/* source/sched_pkg.sv */
// Flow scheduler definitions
`default_nettype none

package sched_pkg;

  // Sizes of the scheduler
  localparam int if_count        = 2;
  localparam int core_count      = 4;
  localparam int slot_count      = 8;
  localparam int slot_width      = 4;
  localparam int core_id_width   = 2;
  localparam int if_id_width     = 1;
  localparam int tag_width       = 5;
  localparam int dest_width      = core_id_width + tag_width;
  localparam int hash_width      = 32;
  localparam int hash_sel_offset = 0;
  localparam int lines_width     = 13;

  localparam logic [lines_width-1:0] drop_limit_reset = {4'd7, {(lines_width-4){1'b0}}};

  // Slot messages from cores
  localparam int msg_type_width = 4;
  localparam logic [msg_type_width-1:0] msg_slot_return = 4'd0;
  localparam logic [msg_type_width-1:0] msg_slot_init   = 4'd3;

  // Host command word layout
  localparam int cmd_wr_bit    = 31;
  localparam int cmd_if_bit    = 30;
  localparam int cmd_sched_bit = 29;
  localparam int cmd_idx_lsb   = 4;
  localparam int cmd_reg_width = 4;

  // Core side register codes
  localparam logic [cmd_reg_width-1:0] reg_enabled    = 4'd0;
  localparam logic [cmd_reg_width-1:0] reg_income     = 4'd1;
  localparam logic [cmd_reg_width-1:0] reg_flush      = 4'd2;
  localparam logic [cmd_reg_width-1:0] reg_slot_count = 4'd3;
  // Interface side register codes
  localparam logic [cmd_reg_width-1:0] reg_drop_count = 4'd2;
  localparam logic [cmd_reg_width-1:0] reg_drop_limit = 4'd3;

  localparam logic [31:0] rd_default = 32'hFEFEFEFE;

endpackage

`default_nettype wire

/* source/slot_keeper.sv */
// Free slot queue of one core
`default_nettype none

module slot_keeper (
  input  logic                             clk,
  input  logic                             rst_r,
  input  logic                             flush,
  input  logic                             init_valid,
  input  logic [sched_pkg::slot_width-1:0] init_slots,
  input  logic                             return_valid,
  input  logic [sched_pkg::slot_width-1:0] return_slot,
  input  logic                             pop,
  output logic [sched_pkg::slot_width-1:0] head,
  output logic                             head_valid,
  output logic [sched_pkg::slot_width-1:0] count,
  output logic                             enq_err
);
  import sched_pkg::*;

  logic [slot_width-1:0]         mem [slot_count];
  logic [$clog2(slot_count)-1:0] rd_ptr;
  logic [$clog2(slot_count)-1:0] wr_ptr;
  logic [slot_width-1:0]         init_n;
  logic                          push;

  // Init requests beyond the queue depth are clamped
  assign init_n = (init_slots > slot_width'(slot_count)) ? slot_width'(slot_count) : init_slots;

  assign push       = return_valid && (count != slot_width'(slot_count));
  assign enq_err    = return_valid && (count == slot_width'(slot_count));
  assign head       = mem[rd_ptr];
  assign head_valid = (count != '0);

  // Init writes slots 1..n from the bottom of the ring
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int k = 0; k < slot_count; k++) begin
        mem[k] <= slot_width'(k + 1);
      end
    end else if (push) begin
      mem[wr_ptr] <= return_slot;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init_valid) begin
      rd_ptr <= '0;
      wr_ptr <= init_n[$clog2(slot_count)-1:0];
      count  <= init_n;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // The allocator only takes a slot this queue actually holds
  pop_needs_slot: assert property (@(posedge clk) disable iff (rst_r) pop |-> head_valid);

endmodule

`default_nettype wire

/* source/slot_pool.sv */
// Slot message decode and per-core slot queues
`default_nettype none

module slot_pool (
  input  logic                                                    clk,
  input  logic                                                    rst_r,
  input  logic                                                    ctrl_valid,
  input  logic [sched_pkg::msg_type_width-1:0]                    ctrl_type,
  input  logic [sched_pkg::core_id_width-1:0]                     ctrl_core,
  input  logic [sched_pkg::slot_width-1:0]                        ctrl_slot,
  input  logic [sched_pkg::core_count-1:0]                        slots_flush,
  input  logic [sched_pkg::core_count-1:0]                        slot_pop,
  output logic [sched_pkg::core_count-1:0][sched_pkg::slot_width-1:0] slot_head,
  output logic [sched_pkg::core_count-1:0]                        slot_head_valid,
  output logic [sched_pkg::core_count-1:0][sched_pkg::slot_width-1:0] slot_count,
  output logic                                                    slot_err
);
  import sched_pkg::*;

  logic                      msg_valid_r;
  logic [msg_type_width-1:0] msg_type_r;
  logic [core_id_width-1:0]  msg_core_r;
  logic [slot_width-1:0]     msg_slot_r;
  logic [slot_width-1:0]     slot_in_r;
  logic [core_count-1:0]     init_v;
  logic [core_count-1:0]     ret_v;
  logic [core_count-1:0]     keeper_err;

  // Message register, messages are always accepted
  always_ff @(posedge clk) begin
    if (rst_r) begin
      msg_valid_r <= 1'b0;
    end else begin
      msg_valid_r <= ctrl_valid;
    end
  end

  always_ff @(posedge clk) begin
    msg_type_r <= ctrl_type;
    msg_core_r <= ctrl_core;
    msg_slot_r <= ctrl_slot;
    slot_in_r  <= msg_slot_r;
  end

  // Decode into per-core strobes, other message types are ignored
  always_ff @(posedge clk) begin
    if (rst_r) begin
      init_v   <= '0;
      ret_v    <= '0;
      slot_err <= 1'b0;
    end else begin
      for (int c = 0; c < core_count; c++) begin
        init_v[c] <= msg_valid_r && (msg_type_r == msg_slot_init) &&
                     (msg_core_r == core_id_width'(c));
        ret_v[c]  <= msg_valid_r && (msg_type_r == msg_slot_return) &&
                     (msg_core_r == core_id_width'(c));
      end
      slot_err <= |keeper_err;
    end
  end

  for (genvar c = 0; c < core_count; c++) begin : g_keeper
    slot_keeper u_keeper (
      .clk         (clk),
      .rst_r       (rst_r),
      .flush       (slots_flush[c]),
      .init_valid  (init_v[c]),
      .init_slots  (slot_in_r),
      .return_valid(ret_v[c]),
      .return_slot (slot_in_r),
      .pop         (slot_pop[c]),
      .head        (slot_head[c]),
      .head_valid  (slot_head_valid[c]),
      .count       (slot_count[c]),
      .enq_err     (keeper_err[c])
    );
  end

endmodule

`default_nettype wire

/* tb/flow_sched_tb.sv */
// Flow scheduler testbench
`default_nettype none

module flow_sched_tb;
  import sched_pkg::*;

  localparam int clk_period    = 4;
  localparam int drive_delay   = 1;
  localparam int pop_timeout   = 20;
  localparam int flow_total    = 20;
  localparam int reg_total     = 40;
  localparam int msg_total     = 12;
  localparam int script_cycles = flow_total * pop_timeout + reg_total * 8 + msg_total * 4 + 40;
  localparam int watchdog_time = 2 * script_cycles * clk_period;

  logic                                  clk;
  logic                                  rst_r;
  logic                                  ctrl_valid;
  logic [msg_type_width-1:0]             ctrl_type;
  logic [core_id_width-1:0]              ctrl_core;
  logic [slot_width-1:0]                 ctrl_slot;
  logic [if_count-1:0]                   hash_valid;
  logic [if_count-1:0][hash_width-1:0]   hash_value;
  logic [if_count-1:0][lines_width-1:0]  line_count;
  logic [31:0]                           host_cmd;
  logic [31:0]                           host_wr_data;
  logic                                  host_cmd_valid;
  logic [if_count-1:0]                   hash_pop;
  logic [if_count-1:0]                   alloc_valid;
  logic [if_count-1:0]                   alloc_drop;
  logic [if_count-1:0][dest_width-1:0]   alloc_dest;
  logic [31:0]                           host_rd_data;
  logic                                  slot_err;

  // Reference model state
  int                    model_mem [core_count][slot_count];
  int                    model_head [core_count];
  int                    model_cnt [core_count];
  int                    model_drops [if_count];
  int                    model_limit;
  logic [core_count-1:0] model_enabled;
  logic [core_count-1:0] model_income;
  logic [if_count-1:0]   popped;
  logic                  err_seen;

  tb_clock_gen #(.period(clk_period)) u_clk (.clk(clk));

  flow_sched_top i_flow_sched_top (
    .clk(clk), .rst_r(rst_r),
    .ctrl_valid(ctrl_valid), .ctrl_type(ctrl_type),
    .ctrl_core(ctrl_core), .ctrl_slot(ctrl_slot),
    .hash_valid(hash_valid), .hash_value(hash_value), .line_count(line_count),
    .host_cmd(host_cmd), .host_wr_data(host_wr_data), .host_cmd_valid(host_cmd_valid),
    .hash_pop(hash_pop), .alloc_valid(alloc_valid), .alloc_drop(alloc_drop),
    .alloc_dest(alloc_dest), .host_rd_data(host_rd_data), .slot_err(slot_err)
  );

  task automatic abort(input string why);
    $display("%s at time %0t", why, $time);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected) begin
      $display("mismatch at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "run stopped on the first mismatch");
    end
  endtask

  // Expected {pop, drop, dest} for a hash on an interface
  function automatic logic [dest_width+1:0] expect_outcome(input logic [hash_width-1:0] hash,
                                                           input int iface);
    int core;
    core = int'(hash[hash_sel_offset +: core_id_width]);
    if (model_cnt[core] > 0 && model_income[core]) begin
      return {2'b10, core_id_width'(core), tag_width'(model_mem[core][model_head[core]])};
    end
    if (int'(line_count[iface]) >= model_limit) begin
      return {2'b11, core_id_width'(core), tag_width'(0)};
    end
    return '0;
  endfunction

  task automatic check_alloc(input int iface);
    logic [dest_width+1:0] outcome;
    int core;
    outcome = expect_outcome(hash_value[iface], iface);
    core = int'(hash_value[iface][hash_sel_offset +: core_id_width]);
    compare(32'(outcome[dest_width+1]), 32'd1,
            $sformatf("pop with no slot and no drop on interface %0d", iface));
    compare(32'(alloc_drop[iface]), 32'(outcome[dest_width]), "drop flag");
    if (outcome[dest_width]) begin
      // Slot tag of a drop is not meaningful
      compare(32'(alloc_dest[iface][dest_width-1 -: core_id_width]), 32'(core), "drop core");
      model_drops[iface]++;
    end else begin
      compare(32'(alloc_dest[iface]), 32'(outcome[dest_width-1:0]), "allocated dest");
      model_head[core] = (model_head[core] + 1) % slot_count;
      model_cnt[core]--;
    end
    popped[iface] = 1'b1;
  endtask

  always @(negedge clk) begin
    if (!rst_r) begin
      compare(32'(alloc_valid & ~hash_valid), 32'd0, "alloc valid without a pending hash");
      compare(32'(hash_pop), 32'(alloc_valid), "hash pop differs from alloc valid");
      for (int i = 0; i < if_count; i++) begin
        if (alloc_valid[i]) begin
          check_alloc(i);
        end
      end
      if (slot_err) begin
        err_seen = 1'b1;
      end
    end
  end

  task automatic tick();
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) tick();
  endtask

  function automatic logic [31:0] make_cmd(input bit wr, input bit to_if, input int idx,
                                           input logic [cmd_reg_width-1:0] code);
    logic [31:0] cmd;
    cmd = '0;
    cmd[cmd_wr_bit] = wr;
    cmd[cmd_if_bit] = to_if;
    cmd[cmd_sched_bit] = 1'b1;
    cmd[cmd_idx_lsb +: 4] = 4'(idx);
    cmd[cmd_reg_width-1:0] = code;
    return cmd;
  endfunction

  task automatic write_reg(input bit to_if, input int idx, input logic [cmd_reg_width-1:0] code,
                           input logic [31:0] data);
    host_cmd = make_cmd(1'b1, to_if, idx, code);
    host_wr_data = data;
    host_cmd_valid = 1'b1;
    if (!to_if && code == reg_enabled) begin
      model_enabled = data[core_count-1:0];
      model_income = model_income & data[core_count-1:0];
    end else if (!to_if && code == reg_income) begin
      model_income = data[core_count-1:0] & model_enabled;
    end else if (!to_if && code == reg_flush) begin
      for (int c = 0; c < core_count; c++) begin
        if (data[c]) begin
          model_cnt[c] = 0;
          model_head[c] = 0;
        end
      end
    end else if (to_if && code == reg_drop_limit) begin
      model_limit = int'(data[lines_width-1:0]);
    end
    tick();
    host_cmd_valid = 1'b0;
    host_cmd = '0;
    idle(3);
  endtask

  task automatic check_reg(input bit to_if, input int idx, input logic [cmd_reg_width-1:0] code,
                           input logic [31:0] expected, input string what);
    host_cmd = make_cmd(1'b0, to_if, idx, code);
    idle(4);
    @(negedge clk);
    compare(host_rd_data, expected, what);
    tick();
  endtask

  task automatic slot_msg(input logic [msg_type_width-1:0] kind, input int core, input int slot);
    int tail;
    ctrl_valid = 1'b1;
    ctrl_type = kind;
    ctrl_core = core_id_width'(core);
    ctrl_slot = slot_width'(slot);
    if (kind == msg_slot_init) begin
      for (int k = 0; k < slot_count; k++) begin
        model_mem[core][k] = k + 1;
      end
      model_head[core] = 0;
      model_cnt[core] = (slot > slot_count) ? slot_count : slot;
    end else if (model_cnt[core] < slot_count) begin
      tail = (model_head[core] + model_cnt[core]) % slot_count;
      model_mem[core][tail] = slot;
      model_cnt[core]++;
    end
    tick();
    ctrl_valid = 1'b0;
  endtask

  function automatic logic [hash_width-1:0] flow_hash(input int core);
    logic [hash_width-1:0] h;
    h = $urandom();
    h[hash_sel_offset +: core_id_width] = core_id_width'(core);
    return h;
  endfunction

  task automatic start_flow(input int iface, input logic [hash_width-1:0] hash);
    popped[iface] = 1'b0;
    hash_value[iface] = hash;
    hash_valid[iface] = 1'b1;
  endtask

  task automatic wait_pop(input int iface);
    int waited;
    waited = 0;
    while (!popped[iface]) begin
      tick();
      waited++;
      if (waited > pop_timeout) begin
        abort($sformatf("no hash pop on interface %0d within %0d cycles", iface, pop_timeout));
      end
    end
  endtask

  task automatic send_flow(input int iface, input logic [hash_width-1:0] hash);
    start_flow(iface, hash);
    wait_pop(iface);
    hash_valid[iface] = 1'b0;
  endtask

  task automatic random_flows(input int iface, input int count);
    for (int n = 0; n < count; n++) begin
      send_flow(iface, flow_hash(1 + int'($urandom() % 2)));
    end
  endtask

  initial begin
    #watchdog_time;
    abort("watchdog expired before the test script finished");
  end

  initial begin
    rst_r = 1'b1;
    ctrl_valid = 1'b0;
    ctrl_type = '0;
    ctrl_core = '0;
    ctrl_slot = '0;
    hash_valid = '0;
    hash_value = '0;
    line_count = '0;
    host_cmd = '0;
    host_wr_data = '0;
    host_cmd_valid = 1'b0;
    popped = '0;
    err_seen = 1'b0;
    model_enabled = '0;
    model_income = '0;
    model_limit = int'(drop_limit_reset);
    for (int c = 0; c < core_count; c++) begin
      model_head[c] = 0;
      model_cnt[c] = 0;
    end
    for (int i = 0; i < if_count; i++) begin
      model_drops[i] = 0;
    end
    void'($urandom(32'h84c44778));
    repeat (3) @(posedge clk);
    #drive_delay;
    rst_r = 1'b0;

    // State after reset
    idle(4);
    check_reg(1'b0, 0, reg_enabled, 32'd0, "enabled after reset");
    check_reg(1'b0, 0, reg_income, 32'd0, "income after reset");
    for (int c = 0; c < core_count; c++) begin
      check_reg(1'b0, c, reg_slot_count, 32'd0, "slot count after reset");
    end
    check_reg(1'b0, 0, 4'hF, rd_default, "unknown register code");

    // Income is always limited to enabled cores
    write_reg(1'b0, 0, reg_income, 32'hF);
    check_reg(1'b0, 0, reg_income, 32'd0, "income before any enable");
    write_reg(1'b0, 0, reg_enabled, 32'hB);
    check_reg(1'b0, 0, reg_enabled, 32'hB, "enabled mask");
    write_reg(1'b0, 0, reg_income, 32'hF);
    check_reg(1'b0, 0, reg_income, 32'hB, "income trimmed by enabled");
    write_reg(1'b0, 0, reg_enabled, 32'h3);
    check_reg(1'b0, 0, reg_income, 32'h3, "income after enabled rewrite");
    write_reg(1'b0, 0, reg_enabled, 32'hF);
    write_reg(1'b0, 0, reg_income, 32'h7);
    check_reg(1'b0, 0, reg_income, 32'h7, "income with core 3 left out");

    // Slots 1..n in order, then returned slots in return order
    slot_msg(msg_slot_init, 0, 5);
    idle(3);
    check_reg(1'b0, 0, reg_slot_count, 32'd5, "slot count after init");
    for (int n = 0; n < 5; n++) begin
      send_flow(0, flow_hash(0));
      check_reg(1'b0, 0, reg_slot_count, 32'(4 - n), "slot count after an allocation");
    end
    slot_msg(msg_slot_return, 0, 3);
    slot_msg(msg_slot_return, 0, 1);
    slot_msg(msg_slot_return, 0, 4);
    idle(3);
    for (int n = 0; n < 3; n++) begin
      send_flow(1, flow_hash(0));
    end

    // Both interfaces competing for two cores
    slot_msg(msg_slot_init, 1, 8);
    slot_msg(msg_slot_init, 2, 8);
    idle(3);
    fork
      random_flows(0, 4);
      random_flows(1, 4);
    join
    check_reg(1'b0, 1, reg_slot_count, 32'(model_cnt[1]), "core 1 slot count");
    check_reg(1'b0, 2, reg_slot_count, 32'(model_cnt[2]), "core 2 slot count");

    // Drops above the limit, waiting below it
    slot_msg(msg_slot_init, 3, 2);
    write_reg(1'b1, 0, reg_drop_limit, 32'd100);
    line_count[0] = 13'(100 + $urandom_range(0, 50));
    line_count[1] = 13'($urandom_range(0, 99));
    idle(3);
    send_flow(0, flow_hash(3));
    send_flow(0, flow_hash(0));
    check_reg(1'b1, 0, reg_drop_count, 32'(model_drops[0]), "drop count of interface 0");
    start_flow(1, flow_hash(0));
    idle(10);
    slot_msg(msg_slot_return, 0, 6);
    wait_pop(1);
    hash_valid[1] = 1'b0;
    check_reg(1'b1, 1, reg_drop_count, 32'(model_drops[1]), "drop count of interface 1");

    // Flush and overflow
    compare(32'(err_seen), 32'd0, "slot error before any overflow");
    write_reg(1'b0, 0, reg_flush, 32'h2);
    check_reg(1'b0, 1, reg_slot_count, 32'd0, "slot count after flush");
    slot_msg(msg_slot_init, 2, 8);
    idle(3);
    check_reg(1'b0, 2, reg_slot_count, 32'd8, "slot count of a full core");
    slot_msg(msg_slot_return, 2, 5);
    idle(5);
    compare(32'(err_seen), 32'd1, "slot error after a return to a full core");
    check_reg(1'b0, 2, reg_slot_count, 32'(slot_count), "slot count after overflow");

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// Testbench clock source
`default_nettype none

module tb_clock_gen #(
  parameter int period = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire
